/* list.f */
src/fifo_cfg_pkg.sv
src/gray_code_pkg.sv
src/fifo_mem_if.sv
src/fifo_ptr_sync.sv
src/fifo_dual_port_ram.sv
src/fifo_write_ctrl.sv
src/fifo_read_ctrl.sv
src/async_fifo.sv
test/async_fifo_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = async_fifo_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '>>> PASS' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* test/async_fifo_tb.sv */
`timescale 1ns/1ps

module async_fifo_tb;

    import fifo_cfg_pkg::*;

    localparam int DATA_W    = DATA_W_DEF;
    localparam int ADDR_W    = ADDR_W_DEF;
    localparam int DEPTH     = 1 << ADDR_W;
    localparam int N_RAND    = 600;
    localparam int PHASE_LEN = 150;
    localparam int MAX_GAP   = 3;
    localparam int N_DROP    = 8;
    localparam int N_EMPTY   = 4;
    localparam int RD_PAT    = 1024;
    // wclk period over rclk period rounded up
    localparam int CLK_RATIO = 2;
    localparam int TOTAL_XFER  = N_RAND + DEPTH + N_DROP + 2 * N_EMPTY;
    // each transfer may sit behind up to MAX_GAP idle cycles
    localparam int TIMEOUT_CYC = 2 * TOTAL_XFER * CLK_RATIO * (MAX_GAP + 1) + 500;

    logic              wclk;
    logic              rclk;
    logic              rst_n;
    logic              winc;
    logic [DATA_W-1:0] wdata;
    logic              wfull;
    logic              rinc;
    logic [DATA_W-1:0] rdata;
    logic              rempty;

    integer seed;
    int     cycles;
    int     data_errs;
    int     flag_errs;
    int     n_checked;

    // reference model with the oldest word at the front
    logic [DATA_W-1:0] model [$];

    // random stimulus drawn up front
    logic [DATA_W-1:0] wr_data [N_RAND];
    int                wr_gap  [N_RAND];
    int                rd_roll [RD_PAT];

    async_fifo #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) DUT (
        .wclk   (wclk),
        .rclk   (rclk),
        .rst_n  (rst_n),
        .winc   (winc),
        .wdata  (wdata),
        .wfull  (wfull),
        .rinc   (rinc),
        .rdata  (rdata),
        .rempty (rempty)
    );

    always #4 rclk = ~rclk;
    always #6 wclk = ~wclk;

    always @(posedge rclk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d rclk cycles", TIMEOUT_CYC);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic log_flag_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        flag_errs++;
    endtask

    task automatic log_data_error(input string what, input logic [DATA_W-1:0] exp_word,
                                  input logic [DATA_W-1:0] got_word);
        $display("ERROR %0t: %s expected %h got %h", $time, what, exp_word, got_word);
        data_errs++;
    endtask

    // percent chance of writing in each phase of the random run
    function automatic int write_density(input int idx);
        int pct;
        case (idx / PHASE_LEN)
            0:       pct = 85;
            1:       pct = 50;
            2:       pct = 30;
            default: pct = 70;
        endcase
        return pct;
    endfunction

    function automatic int read_density(input int idx);
        int pct;
        case (idx / PHASE_LEN)
            0:       pct = 45;
            1:       pct = 90;
            2:       pct = 60;
            default: pct = 75;
        endcase
        return pct;
    endfunction

    task automatic prepare_stimulus();
        int gap;
        int roll;
        for (int i = 0; i < N_RAND; i++) begin
            wr_data[i] = $random(seed);
            gap = 0;
            roll = $unsigned($random(seed)) % 100;
            while (gap < MAX_GAP && roll >= write_density(i)) begin
                gap++;
                roll = $unsigned($random(seed)) % 100;
            end
            wr_gap[i] = gap;
        end
        for (int i = 0; i < RD_PAT; i++) begin
            rd_roll[i] = $unsigned($random(seed)) % 100;
        end
    endtask

    task automatic idle_write(input int n);
        repeat (n) begin
            @(posedge wclk);
            #1;
        end
    endtask

    // hold winc until a wclk edge sees wfull low
    task automatic write_word(input logic [DATA_W-1:0] word);
        logic was_full;
        logic done;
        winc  = 1'b1;
        wdata = word;
        done  = 1'b0;
        while (!done) begin
            // wfull only moves on posedge wclk
            @(negedge wclk);
            was_full = wfull;
            @(posedge wclk);
            #1;
            if (!was_full) begin
                model.push_back(word);
                done = 1'b1;
            end
        end
        winc = 1'b0;
    endtask

    // one rclk cycle with rinc = want
    task automatic read_step(input logic want, output logic took);
        logic              was_empty;
        logic [DATA_W-1:0] held;
        logic [DATA_W-1:0] exp_word;
        rinc = want;
        @(negedge rclk);
        was_empty = rempty;
        held      = rdata;
        @(posedge rclk);
        #1;
        took = want & ~was_empty;
        if (took) begin
            if (model.size() == 0) begin
                log_flag_error("read accepted with no word in the model");
            end else begin
                exp_word = model.pop_front();
                n_checked++;
                if (rdata !== exp_word) begin
                    log_data_error("rdata", exp_word, rdata);
                end
            end
        end else if (rdata !== held) begin
            log_data_error("rdata hold", held, rdata);
        end
    endtask

    task automatic check_reset_state();
        if (rempty !== 1'b1) begin
            log_flag_error("rempty is not 1 after reset");
        end
        if (wfull !== 1'b0) begin
            log_flag_error("wfull is not 0 after reset");
        end
        if (rdata !== '0) begin
            log_data_error("rdata after reset", '0, rdata);
        end
    endtask

    task automatic reads_while_empty(input int n);
        logic took;
        if (rempty !== 1'b1) begin
            log_flag_error("rempty is low before the empty read test");
        end
        for (int i = 0; i < n; i++) begin
            read_step(1'b1, took);
            if (took) begin
                log_flag_error("read accepted while rempty was high");
            end
        end
        rinc = 1'b0;
    endtask

    task automatic random_traffic();
        int   n_rd;
        int   idx;
        logic want;
        logic took;
        n_rd = 0;
        idx  = 0;
        fork
            begin
                @(posedge wclk);
                #1;
                for (int i = 0; i < N_RAND; i++) begin
                    idle_write(wr_gap[i]);
                    write_word(wr_data[i]);
                end
            end
            begin
                while (n_rd < N_RAND) begin
                    want = (rd_roll[idx % RD_PAT] < read_density(n_rd));
                    read_step(want, took);
                    if (took) begin
                        n_rd++;
                    end
                    idx++;
                end
                rinc = 1'b0;
            end
        join
        if (model.size() != 0) begin
            log_flag_error($sformatf("%0d words never came out", model.size()));
        end
    endtask

    task automatic fill_to_full();
        logic [DATA_W-1:0] word;
        while (!rempty) begin
            @(posedge rclk);
        end
        // read pointer still has to cross into wclk
        repeat (4) @(posedge wclk);
        #1;
        for (int i = 0; i < DEPTH; i++) begin
            word = $random(seed);
            write_word(word);
            if (wfull !== (i == DEPTH - 1)) begin
                log_flag_error($sformatf("wfull is %b after write %0d of %0d",
                                         wfull, i + 1, DEPTH));
            end
        end
        // these must be dropped
        winc = 1'b1;
        for (int i = 0; i < N_DROP; i++) begin
            wdata = $random(seed);
            @(negedge wclk);
            if (wfull !== 1'b1) begin
                log_flag_error("wfull dropped while no read was made");
            end
            @(posedge wclk);
            #1;
        end
        winc = 1'b0;
    endtask

    task automatic drain_to_empty();
        int   expected;
        int   n_drained;
        logic took;
        expected  = model.size();
        n_drained = 0;
        @(posedge rclk);
        #1;
        while (!rempty) begin
            read_step(1'b1, took);
            if (took) begin
                n_drained++;
                if (rempty !== (model.size() == 0)) begin
                    log_flag_error($sformatf("rempty is %b after read %0d of %0d",
                                             rempty, n_drained, expected));
                end
            end
        end
        rinc = 1'b0;
        if (n_drained != expected) begin
            log_flag_error($sformatf("drained %0d words, model held %0d",
                                     n_drained, expected));
        end
    endtask

    initial begin
        rclk      = 1'b0;
        wclk      = 1'b0;
        rst_n     = 1'b0;
        winc      = 1'b0;
        wdata     = '0;
        rinc      = 1'b0;
        seed      = 32'hca9e;
        cycles    = 0;
        data_errs = 0;
        flag_errs = 0;
        n_checked = 0;

        prepare_stimulus();

        repeat (10) @(posedge rclk);
        #1;
        rst_n = 1'b1;

        check_reset_state();
        reads_while_empty(N_EMPTY);
        random_traffic();
        fill_to_full();
        drain_to_empty();
        // rdata should still show the last drained word
        reads_while_empty(N_EMPTY);

        $display("done: %0d words checked, %0d data errors, %0d flag errors",
                 n_checked, data_errs, flag_errs);
        if (data_errs == 0 && flag_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* src/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
    parameter int DATA_W = fifo_cfg_pkg::DATA_W_DEF,
    parameter int ADDR_W = fifo_cfg_pkg::ADDR_W_DEF
) (
    input  logic              wclk,
    input  logic              rclk,
    input  logic              rst_n,
    input  logic              winc,
    input  logic [DATA_W-1:0] wdata,
    output logic              wfull,
    input  logic              rinc,
    output logic [DATA_W-1:0] rdata,
    output logic              rempty
);

    import fifo_cfg_pkg::*;

    localparam int PTR_W = ptr_width(ADDR_W);

    // gray pointers, raw and after crossing
    logic [PTR_W-1:0] wptr_gray;
    logic [PTR_W-1:0] wptr_gray_sync;
    logic [PTR_W-1:0] rptr_gray;
    logic [PTR_W-1:0] rptr_gray_sync;

    fifo_mem_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) wr_port (.clk(wclk));
    fifo_mem_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) rd_port (.clk(rclk));

    fifo_write_ctrl #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_write_ctrl (
        .wclk           (wclk),
        .rst_n          (rst_n),
        .winc           (winc),
        .wdata          (wdata),
        .rptr_gray_sync (rptr_gray_sync),
        .wfull          (wfull),
        .wptr_gray      (wptr_gray),
        .mem            (wr_port.wr_ctrl)
    );

    // write pointer into the read domain
    fifo_ptr_sync #(.PTR_W(PTR_W)) u_wptr_sync (
        .clk     (rclk),
        .rst_n   (rst_n),
        .ptr_in  (wptr_gray),
        .ptr_out (wptr_gray_sync)
    );

    // read pointer into the write domain
    fifo_ptr_sync #(.PTR_W(PTR_W)) u_rptr_sync (
        .clk     (wclk),
        .rst_n   (rst_n),
        .ptr_in  (rptr_gray),
        .ptr_out (rptr_gray_sync)
    );

    fifo_dual_port_ram #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_ram (
        .wr (wr_port.wr_ram),
        .rd (rd_port.rd_ram)
    );

    fifo_read_ctrl #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_read_ctrl (
        .rclk           (rclk),
        .rst_n          (rst_n),
        .rinc           (rinc),
        .wptr_gray_sync (wptr_gray_sync),
        .rdata          (rdata),
        .rempty         (rempty),
        .rptr_gray      (rptr_gray),
        .mem            (rd_port.rd_ctrl)
    );

endmodule

/* src/fifo_read_ctrl.sv */
`timescale 1ns/1ps

module fifo_read_ctrl #(
    parameter int DATA_W = fifo_cfg_pkg::DATA_W_DEF,
    parameter int ADDR_W = fifo_cfg_pkg::ADDR_W_DEF
) (
    input  logic              rclk,
    input  logic              rst_n,
    input  logic              rinc,
    input  logic [ADDR_W:0]   wptr_gray_sync,
    output logic [DATA_W-1:0] rdata,
    output logic              rempty,
    output logic [ADDR_W:0]   rptr_gray,
    fifo_mem_if.rd_ctrl       mem
);

    import gray_code_pkg::*;

    localparam int PTR_W = ADDR_W + 1;

    logic             rd_accept;
    logic [PTR_W-1:0] rbin;
    logic [PTR_W-1:0] rbin_next;
    logic [PTR_W-1:0] rgray_next;

    // reads while empty are ignored, rdata holds
    assign rd_accept = rinc & ~rempty;

    assign rbin       = PTR_W'(gray2bin(gray_word_t'(rptr_gray)));
    assign rbin_next  = rbin + PTR_W'(rd_accept);
    assign rgray_next = PTR_W'(bin2gray(gray_word_t'(rbin_next)));

    // current pointer addresses the oldest word
    assign mem.addr = rbin[ADDR_W-1:0];
    assign mem.en   = rd_accept;

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rptr_gray <= '0;
            rempty    <= 1'b1;
        end else begin
            rptr_gray <= rgray_next;
            // equal pointers incl. wrap bit means nothing left
            rempty    <= (rgray_next == wptr_gray_sync);
        end
    end

    // output register, loaded only on an accepted read
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_accept) begin
            rdata <= mem.data;
        end
    end

endmodule

/* src/fifo_write_ctrl.sv */
`timescale 1ns/1ps

module fifo_write_ctrl #(
    parameter int DATA_W = fifo_cfg_pkg::DATA_W_DEF,
    parameter int ADDR_W = fifo_cfg_pkg::ADDR_W_DEF
) (
    input  logic              wclk,
    input  logic              rst_n,
    input  logic              winc,
    input  logic [DATA_W-1:0] wdata,
    input  logic [ADDR_W:0]   rptr_gray_sync,
    output logic              wfull,
    output logic [ADDR_W:0]   wptr_gray,
    fifo_mem_if.wr_ctrl       mem
);

    import gray_code_pkg::*;

    localparam int PTR_W = ADDR_W + 1;

    logic             wr_accept;
    logic [PTR_W-1:0] wbin;
    logic [PTR_W-1:0] wbin_next;
    logic [PTR_W-1:0] wgray_next;
    logic [PTR_W-1:0] full_match;

    // writes while full are dropped here
    assign wr_accept = winc & ~wfull;

    // binary pointer recovered from the registered gray value
    assign wbin      = PTR_W'(gray2bin(gray_word_t'(wptr_gray)));
    assign wbin_next = wbin + PTR_W'(wr_accept);
    assign wgray_next = PTR_W'(bin2gray(gray_word_t'(wbin_next)));

    // read pointer one lap behind, in gray the top two bits differ
    assign full_match = {~rptr_gray_sync[PTR_W-1:PTR_W-2], rptr_gray_sync[PTR_W-3:0]};

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            wptr_gray <= '0;
            wfull     <= 1'b0;
        end else begin
            wptr_gray <= wgray_next;
            // look ahead so full rises with the filling write
            wfull     <= (wgray_next == full_match);
        end
    end

    // RAM write port
    assign mem.en   = wr_accept;
    assign mem.addr = wbin[ADDR_W-1:0];
    assign mem.data = wdata;

endmodule

/* src/fifo_dual_port_ram.sv */
`timescale 1ns/1ps

module fifo_dual_port_ram #(
    parameter int DATA_W = fifo_cfg_pkg::DATA_W_DEF,
    parameter int ADDR_W = fifo_cfg_pkg::ADDR_W_DEF
) (
    fifo_mem_if.wr_ram wr,
    fifo_mem_if.rd_ram rd
);

    localparam int DEPTH = 1 << ADDR_W;

    // contents undefined until written
    logic [DATA_W-1:0] store [DEPTH];

    // write side, one wclk edge per word
    always_ff @(posedge wr.clk) begin
        if (wr.en) begin
            store[wr.addr] <= wr.data;
        end
    end

    // read side is asynchronous, the read controller registers it
    assign rd.data = store[rd.addr];

endmodule

/* src/fifo_ptr_sync.sv */
`timescale 1ns/1ps

module fifo_ptr_sync #(
    parameter int PTR_W = fifo_cfg_pkg::ptr_width(fifo_cfg_pkg::ADDR_W_DEF)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [PTR_W-1:0] ptr_in,
    output logic [PTR_W-1:0] ptr_out
);

    // first stage may go metastable
    logic [PTR_W-1:0] meta;

    // only gray values pass through here, so at most one bit moves
    // per source update and a late sample is off by one step at most
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta    <= '0;
            ptr_out <= '0;
        end else begin
            meta    <= ptr_in;
            ptr_out <= meta;
        end
    end

endmodule

/* src/fifo_mem_if.sv */
`timescale 1ns/1ps

interface fifo_mem_if #(
    parameter int DATA_W = fifo_cfg_pkg::DATA_W_DEF,
    parameter int ADDR_W = fifo_cfg_pkg::ADDR_W_DEF
) (
    input logic clk
);

    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;

    // write port, controller drives everything, RAM samples on clk
    modport wr_ctrl (output en, output addr, output data);
    modport wr_ram  (input clk, input en, input addr, input data);

    // read port, data comes back combinationally from addr
    modport rd_ctrl (output en, output addr, input data);
    modport rd_ram  (input addr, output data);

endinterface

/* src/gray_code_pkg.sv */
package gray_code_pkg;

    // wide enough for any supported pointer
    // callers zero-extend into it and truncate back
    typedef logic [fifo_cfg_pkg::GRAY_MAX_W-1:0] gray_word_t;

    // reflected gray code, one bit flips per increment
    function automatic gray_word_t bin2gray(gray_word_t bin);
        gray_word_t gray;
        gray = bin ^ (bin >> 1);
        return gray;
    endfunction

    // running xor from the msb down
    function automatic gray_word_t gray2bin(gray_word_t gray);
        gray_word_t bin;
        bin[fifo_cfg_pkg::GRAY_MAX_W-1] = gray[fifo_cfg_pkg::GRAY_MAX_W-1];
        for (int i = fifo_cfg_pkg::GRAY_MAX_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* src/fifo_cfg_pkg.sv */
package fifo_cfg_pkg;

    // default payload width in bits
    parameter int DATA_W_DEF = 32;

    // default address width, 2**6 = 64 words
    parameter int ADDR_W_DEF = 6;

    // widest pointer the gray conversions are sized for
    parameter int GRAY_MAX_W = 16;

    // smallest and largest address widths the pointer logic supports
    parameter int ADDR_W_MIN = 2;
    parameter int ADDR_W_MAX = GRAY_MAX_W - 1;

    // pointer carries one extra wrap bit on top of the address
    function automatic int ptr_width(int addr_w);
        int w;
        w = addr_w + 1;
        if (addr_w < ADDR_W_MIN) begin
            w = ADDR_W_MIN + 1;
        end
        if (addr_w > ADDR_W_MAX) begin
            w = GRAY_MAX_W;
        end
        return w;
    endfunction

endpackage
